// File: logic/conv_defs.svh
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// Window geometry.
`define KERNEL_SIZE 5
`define KERNEL_TAPS (`KERNEL_SIZE * `KERNEL_SIZE)

// Cluster size and channel depth.
`define NUM_UNITS 4
`define MAX_DEPTH 8
`define WM_DEPTH (`KERNEL_TAPS * `MAX_DEPTH)

// Data widths.
`define PIX_W 8
`define WGT_W 8
`define ACC_W 32

`endif

// File: logic/conv_pkg.sv
`default_nettype none

`include "conv_defs.svh"

package conv_pkg;

	typedef logic signed [`PIX_W-1:0] pixel_t;
	typedef logic signed [`WGT_W-1:0] weight_t;
	typedef logic signed [`ACC_W-1:0] acc_t;

	// Address is channel times tap count plus tap.
	typedef logic [$clog2(`WM_DEPTH)-1:0] wm_addr_t;

	typedef logic [$clog2(`NUM_UNITS)-1:0] unit_idx_t;
	typedef logic [$clog2(`MAX_DEPTH+1)-1:0] depth_t;

	typedef enum logic [1:0] {
		S_IDLE,
		S_FILL,
		S_ISSUE
	} feeder_state_t;

endpackage

`default_nettype wire

// File: logic/window_bus_if.sv
`default_nettype none

`include "conv_defs.svh"

interface window_bus_if ();
	import conv_pkg::*;

	pixel_t window [`KERNEL_TAPS]; // Tap 0 is the oldest pixel.
	logic wm_rd_en;
	wm_addr_t wm_rd_addr;
	logic conv_strobe;
	logic first; // Qualified by conv_strobe.
	logic last;

	modport feeder (
		output window,
		output wm_rd_en,
		output wm_rd_addr,
		output conv_strobe,
		output first,
		output last
	);

	modport unit (
		input window,
		input wm_rd_en,
		input wm_rd_addr,
		input conv_strobe,
		input first,
		input last
	);

endinterface

`default_nettype wire

// File: logic/cfg_bus_if.sv
`default_nettype none

interface cfg_bus_if ();
	import conv_pkg::*;

	logic wr;
	logic is_bias; // Selects the bias register instead of the weight memory.
	unit_idx_t unit_sel;
	wm_addr_t addr;
	acc_t data; // Weights use the low byte only.

	modport unit (
		input wr,
		input is_bias,
		input unit_sel,
		input addr,
		input data
	);

endinterface

`default_nettype wire

// File: logic/weight_ram.sv
`default_nettype none

module weight_ram #(
	parameter int DEPTH = 200
) (
	input logic clk,
	input logic we,
	input logic re,
	input conv_pkg::wm_addr_t addr,
	input conv_pkg::weight_t wdata,
	output conv_pkg::weight_t rdata
);
	import conv_pkg::*;

	weight_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we) mem[addr] <= wdata;
	end

	// Registered read, so data follows the address by one cycle.
	always_ff @(posedge clk) begin
		if (re) rdata <= mem[addr];
	end

endmodule

`default_nettype wire

// File: logic/dot_product.sv
`default_nettype none

`include "conv_defs.svh"

module dot_product (
	input logic clk,
	input logic rst,
	input logic start,
	input conv_pkg::pixel_t window [`KERNEL_TAPS],
	input conv_pkg::weight_t weights [`KERNEL_TAPS],
	output logic valid,
	output conv_pkg::acc_t sum
);
	import conv_pkg::*;

	acc_t prod [`KERNEL_TAPS];
	acc_t tree;
	logic prod_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			prod_valid <= 1'b0;
			valid <= 1'b0;
		end else begin
			prod_valid <= start;
			valid <= prod_valid;
		end
	end

	// Operands are widened first so the products keep their sign.
	always_ff @(posedge clk) begin
		if (start) begin
			for (int i = 0; i < `KERNEL_TAPS; i++) begin
				prod[i] <= acc_t'(window[i]) * acc_t'(weights[i]);
			end
		end
	end

	always_comb begin
		tree = '0;
		for (int i = 0; i < `KERNEL_TAPS; i++) begin
			tree = tree + prod[i];
		end
	end

	always_ff @(posedge clk) begin
		if (prod_valid) sum <= tree;
	end

endmodule

`default_nettype wire

// File: logic/window_feeder.sv
`default_nettype none

`include "conv_defs.svh"

module window_feeder (
	input logic clk,
	input logic rst,
	input logic pix_valid,
	input conv_pkg::pixel_t pix_data,
	input conv_pkg::depth_t cfg_depth,
	input logic relu_en,
	window_bus_if.feeder win,
	output logic relu_on,
	output logic busy,
	input logic out_done
);
	import conv_pkg::*;

	localparam int TAP_W = $clog2(`KERNEL_TAPS);

	feeder_state_t state;
	logic [TAP_W-1:0] tap;
	depth_t chan;
	depth_t depth_r;
	logic relu_r;
	pixel_t win_sr [`KERNEL_TAPS];
	logic accept;
	logic last_tap;
	logic last_chan;
	logic iss_d1;
	logic first_d1;
	logic last_d1;

	assign accept = pix_valid && (state != S_ISSUE);
	assign last_tap = (tap == TAP_W'(`KERNEL_TAPS - 1));
	assign last_chan = (chan == depth_r - 1'b1);

	// The weight read goes out in the same cycle as the pixel.
	assign win.wm_rd_en = accept;
	assign win.wm_rd_addr = wm_addr_t'(chan) * wm_addr_t'(`KERNEL_TAPS) + wm_addr_t'(tap);

	assign busy = (state != S_IDLE);
	assign relu_on = relu_r;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			tap <= '0;
			chan <= '0;
			depth_r <= '0;
			relu_r <= 1'b0;
			iss_d1 <= 1'b0;
			win.conv_strobe <= 1'b0;
		end else begin
			iss_d1 <= accept && last_tap;
			win.conv_strobe <= iss_d1; // Weight chain completes one cycle after the pixel.
			unique case (state)
				S_IDLE: if (accept) begin
					depth_r <= cfg_depth;
					relu_r <= relu_en;
					state <= S_FILL;
				end
				S_FILL: if (accept && last_tap && last_chan) state <= S_ISSUE;
				S_ISSUE: if (out_done) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
			if (accept) begin
				if (last_tap) begin
					tap <= '0;
					chan <= last_chan ? '0 : chan + 1'b1;
				end else begin
					tap <= tap + 1'b1;
				end
			end
		end
	end

	// The snapshot frees the shift register for the next channel.
	always_ff @(posedge clk) begin
		if (accept) begin
			for (int i = 0; i < `KERNEL_TAPS - 1; i++) begin
				win_sr[i] <= win_sr[i+1];
			end
			win_sr[`KERNEL_TAPS-1] <= pix_data;
		end
		first_d1 <= (chan == '0);
		last_d1 <= last_chan;
		win.first <= first_d1;
		win.last <= last_d1;
		if (iss_d1) win.window <= win_sr;
	end

	a_depth_range: assert property (@(posedge clk) disable iff (rst)
		(state == S_IDLE && accept) |-> (cfg_depth != '0 && cfg_depth <= `MAX_DEPTH));

endmodule

`default_nettype wire

// File: logic/filter_unit.sv
`default_nettype none

`include "conv_defs.svh"

module filter_unit #(
	parameter int UNIT_ID = 0
) (
	input logic clk,
	input logic rst,
	window_bus_if.unit win,
	cfg_bus_if.unit cfg,
	input logic relu_on,
	output logic res_valid,
	output conv_pkg::acc_t res_data
);
	import conv_pkg::*;

	logic wr_hit;
	logic wm_we;
	wm_addr_t wm_addr;
	weight_t wm_rdata;
	logic shift_en;
	weight_t wchain [`KERNEL_TAPS];
	acc_t bias_r;
	acc_t acc_r;
	acc_t dp_sum;
	logic dp_valid;
	logic [1:0] first_p;
	logic [1:0] last_p;

	assign wr_hit = cfg.wr && (cfg.unit_sel == unit_idx_t'(UNIT_ID));
	assign wm_we = wr_hit && !cfg.is_bias;
	assign wm_addr = wm_we ? cfg.addr : win.wm_rd_addr;

	weight_ram #(
		.DEPTH(`WM_DEPTH)
	) u_weight_ram (
		.clk(clk),
		.we(wm_we),
		.re(win.wm_rd_en),
		.addr(wm_addr),
		.wdata(weight_t'(cfg.data)),
		.rdata(wm_rdata)
	);

	always_ff @(posedge clk) begin
		if (rst) shift_en <= 1'b0;
		else shift_en <= win.wm_rd_en;
	end

	always_ff @(posedge clk) begin
		if (wr_hit && cfg.is_bias) bias_r <= cfg.data;
		if (shift_en) begin
			for (int i = 0; i < `KERNEL_TAPS - 1; i++) begin
				wchain[i] <= wchain[i+1];
			end
			wchain[`KERNEL_TAPS-1] <= wm_rdata; // Newest weight enters at the top, like the pixels.
		end
	end

	dot_product u_dot_product (
		.clk(clk),
		.rst(rst),
		.start(win.conv_strobe),
		.window(win.window),
		.weights(wchain),
		.valid(dp_valid),
		.sum(dp_sum)
	);

	// Flags ride alongside the two dot product stages.
	always_ff @(posedge clk) begin
		first_p <= {first_p[0], win.first};
		last_p <= {last_p[0], win.last};
		if (dp_valid) acc_r <= first_p[1] ? bias_r + dp_sum : acc_r + dp_sum;
	end

	always_ff @(posedge clk) begin
		if (rst) res_valid <= 1'b0;
		else res_valid <= dp_valid && last_p[1];
	end

	assign res_data = (relu_on && acc_r < 0) ? '0 : acc_r;

	a_no_wr_collision: assert property (@(posedge clk) disable iff (rst)
		!(wm_we && win.wm_rd_en));

endmodule

`default_nettype wire

// File: logic/result_collector.sv
`default_nettype none

`include "conv_defs.svh"

module result_collector (
	input logic clk,
	input logic rst,
	input logic [`NUM_UNITS-1:0] res_valid,
	input conv_pkg::acc_t res_data [`NUM_UNITS],
	output logic out_valid,
	output conv_pkg::unit_idx_t out_unit,
	output conv_pkg::acc_t out_data,
	output logic out_done
);
	import conv_pkg::*;

	acc_t hold [`NUM_UNITS];
	unit_idx_t idx;
	logic draining;
	logic capture;
	logic last_idx;

	assign capture = |res_valid;
	assign last_idx = (idx == unit_idx_t'(`NUM_UNITS - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			draining <= 1'b0;
			idx <= '0;
		end else if (capture) begin
			draining <= 1'b1;
			idx <= '0;
		end else if (draining) begin
			if (last_idx) begin
				draining <= 1'b0;
				idx <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture) hold <= res_data;
	end

	assign out_valid = draining;
	assign out_unit = idx;
	assign out_data = hold[idx];
	assign out_done = draining && last_idx; // Lets the feeder take the next output.

	a_units_lockstep: assert property (@(posedge clk) disable iff (rst)
		capture |-> (&res_valid));

	a_no_overrun: assert property (@(posedge clk) disable iff (rst)
		draining |-> !capture);

endmodule

`default_nettype wire

// File: logic/conv_cluster.sv
`default_nettype none

`include "conv_defs.svh"

module conv_cluster (
	input logic clk,
	input logic rst,
	input logic pix_valid,
	input conv_pkg::pixel_t pix_data,
	input conv_pkg::depth_t cfg_depth,
	input logic relu_en,
	input logic cfg_wr,
	input logic cfg_is_bias,
	input conv_pkg::unit_idx_t cfg_unit,
	input conv_pkg::wm_addr_t cfg_addr,
	input conv_pkg::acc_t cfg_data,
	output logic out_valid,
	output conv_pkg::unit_idx_t out_unit,
	output conv_pkg::acc_t out_data,
	output logic busy
);
	import conv_pkg::*;

	logic relu_on;
	logic out_done;
	logic [`NUM_UNITS-1:0] res_valid;
	acc_t res_data [`NUM_UNITS];

	window_bus_if win_bus ();
	cfg_bus_if cfg_bus ();

	assign cfg_bus.wr = cfg_wr;
	assign cfg_bus.is_bias = cfg_is_bias;
	assign cfg_bus.unit_sel = cfg_unit;
	assign cfg_bus.addr = cfg_addr;
	assign cfg_bus.data = cfg_data;

	window_feeder u_window_feeder (
		.clk(clk),
		.rst(rst),
		.pix_valid(pix_valid),
		.pix_data(pix_data),
		.cfg_depth(cfg_depth),
		.relu_en(relu_en),
		.win(win_bus.feeder),
		.relu_on(relu_on),
		.busy(busy),
		.out_done(out_done)
	);

	// Every unit sees the same window and differs only in its kernel.
	for (genvar g = 0; g < `NUM_UNITS; g++) begin : g_unit
		filter_unit #(
			.UNIT_ID(g)
		) u_filter_unit (
			.clk(clk),
			.rst(rst),
			.win(win_bus.unit),
			.cfg(cfg_bus.unit),
			.relu_on(relu_on),
			.res_valid(res_valid[g]),
			.res_data(res_data[g])
		);
	end

	result_collector u_result_collector (
		.clk(clk),
		.rst(rst),
		.res_valid(res_valid),
		.res_data(res_data),
		.out_valid(out_valid),
		.out_unit(out_unit),
		.out_data(out_data),
		.out_done(out_done)
	);

endmodule

`default_nettype wire

// File: dv/conv_ref_model.svh
`ifndef CONV_REF_MODEL_SVH
`define CONV_REF_MODEL_SVH

weight_t model_wgt [`NUM_UNITS][`WM_DEPTH];
acc_t model_bias [`NUM_UNITS];
pixel_t stream_pix [`WM_DEPTH]; // One output's pixels, channel major, tap minor.

// Bias plus all tap products of all channels, wrapping at 32 bits like any int sum.
function automatic acc_t expected_result(input int unit, input int depth, input bit relu);
	int acc;
	acc = model_bias[unit];
	for (int i = 0; i < depth * `KERNEL_TAPS; i++) begin
		acc += int'(stream_pix[i]) * int'(model_wgt[unit][i]);
	end
	if (relu && acc < 0) acc = 0;
	return acc;
endfunction

task automatic load_kernel(input int unit, input bit neg_bias);
	acc_t word;
	for (int a = 0; a < `WM_DEPTH; a++) begin
		word = $random(seed);
		@(negedge clk);
		cfg_wr = 1'b1;
		cfg_is_bias = 1'b0;
		cfg_unit = unit_idx_t'(unit);
		cfg_addr = wm_addr_t'(a);
		cfg_data = word; // Only the low byte lands in the weight memory.
		model_wgt[unit][a] = word[`WGT_W-1:0];
	end
	word = $random(seed);
	if (neg_bias) word = -(word & 32'h0000_ffff) - 1;
	@(negedge clk);
	cfg_is_bias = 1'b1;
	cfg_data = word;
	model_bias[unit] = word;
	@(negedge clk);
	cfg_wr = 1'b0;
	cfg_is_bias = 1'b0;
endtask

task automatic fill_stream(input int depth);
	for (int i = 0; i < depth * `KERNEL_TAPS; i++) begin
		stream_pix[i] = pixel_t'($random(seed));
	end
endtask

// Gaps carry junk on pix_data so that ignored cycles are really ignored.
task automatic send_stream(input int depth, input bit relu, input bit with_gaps);
	int n_gap;
	@(negedge clk);
	cfg_depth = depth_t'(depth);
	relu_en = relu;
	for (int i = 0; i < depth * `KERNEL_TAPS; i++) begin
		n_gap = 0;
		if (with_gaps && (($random(seed) & 3) == 0)) n_gap = 1 + ($random(seed) & 1);
		repeat (n_gap) begin
			pix_valid = 1'b0;
			pix_data = pixel_t'($random(seed));
			@(negedge clk);
		end
		pix_valid = 1'b1;
		pix_data = stream_pix[i];
		@(negedge clk);
	end
	pix_valid = 1'b0;
endtask

`endif

// File: dv/tb_conv_cluster.sv
`default_nettype none

`include "conv_defs.svh"

module tb_conv_cluster;
	import conv_pkg::*;

	// Worst case per output is two gap cycles per pixel plus the drain.
	localparam int N_OUTPUTS = 13;
	localparam int N_LOADS = 2 * `NUM_UNITS + 1;
	localparam int CYCLE_LIMIT =
		2 * (N_OUTPUTS * (3 * `WM_DEPTH + 20) + N_LOADS * (`WM_DEPTH + 2) + 20);

	logic clk, rst, pix_valid, relu_en, cfg_wr, cfg_is_bias, out_valid, busy;
	pixel_t pix_data;
	depth_t cfg_depth;
	unit_idx_t cfg_unit, out_unit;
	wm_addr_t cfg_addr;
	acc_t cfg_data, out_data;

	integer seed;
	string cur_test;
	int test_errors, total_errors, tests_run, tests_failed;
	int cycle_count = 0;
	int mon_unit [$];
	acc_t mon_data [$];
	int mon_cycle [$];
	acc_t last_res [`NUM_UNITS];
	acc_t ref_res [`NUM_UNITS];

	`include "conv_ref_model.svh"

	conv_cluster i_conv_cluster (
		.clk(clk), .rst(rst), .pix_valid(pix_valid), .pix_data(pix_data),
		.cfg_depth(cfg_depth), .relu_en(relu_en), .cfg_wr(cfg_wr),
		.cfg_is_bias(cfg_is_bias), .cfg_unit(cfg_unit), .cfg_addr(cfg_addr),
		.cfg_data(cfg_data), .out_valid(out_valid), .out_unit(out_unit),
		.out_data(out_data), .busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (!rst && out_valid) begin
			mon_unit.push_back(out_unit);
			mon_data.push_back(out_data);
			mon_cycle.push_back(cycle_count);
		end
	end

	initial begin
		wait (cycle_count >= CYCLE_LIMIT);
		$display("ERROR %s: timeout after %0d cycles waiting for the DUT",
			cur_test, CYCLE_LIMIT);
		$display("TB FAILED");
		$finish;
	end

	task automatic note_mismatch(input string what, input acc_t expv, input acc_t actv);
		$display("FAIL %s: %s expected %0d actual %0d", cur_test, what, expv, actv);
		test_errors++;
	endtask

	task automatic note_problem(input string text);
		$display("ERROR %s: %s", cur_test, text);
		test_errors++;
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		total_errors += test_errors;
		if (test_errors != 0) tests_failed++;
		$display("test %s: %s, %0d errors",
			cur_test, test_errors == 0 ? "ok" : "bad", test_errors);
	endtask

	// Streams one output and checks the four words that the collector drains.
	task automatic run_output(input int depth, input bit relu, input bit with_gaps);
		acc_t exp_val;
		if (mon_unit.size() != 0) note_problem("output words appeared with no output in flight");
		mon_unit.delete();
		mon_data.delete();
		mon_cycle.delete();
		send_stream(depth, relu, with_gaps);
		if (mon_unit.size() != 0) note_problem("output appeared before the last channel was sent");
		if (busy !== 1'b1) note_problem("busy is low while an output is in flight");
		while (mon_unit.size() < `NUM_UNITS) @(negedge clk);
		if (busy !== 1'b0) note_problem("busy still high after the last output word");
		repeat (4) @(negedge clk);
		if (mon_unit.size() != `NUM_UNITS) note_problem("extra output words after the last unit");
		for (int u = 0; u < `NUM_UNITS; u++) begin
			exp_val = expected_result(u, depth, relu);
			if (mon_unit[u] != u) begin
				note_mismatch($sformatf("unit index of word %0d", u), u, mon_unit[u]);
			end
			if (mon_cycle[u] != mon_cycle[0] + u) begin
				note_problem("output words not on consecutive cycles");
			end
			if (mon_data[u] !== exp_val) begin
				note_mismatch($sformatf("unit %0d result", u), exp_val, mon_data[u]);
			end
			last_res[u] = mon_data[u];
		end
		mon_unit.delete();
		mon_data.delete();
		mon_cycle.delete();
	endtask

	initial begin
		int depth;
		int pick;
		seed = 14;
		rst = 1'b1;
		pix_valid = 1'b0;
		pix_data = '0;
		cfg_depth = depth_t'(1);
		relu_en = 1'b0;
		cfg_wr = 1'b0;
		cfg_is_bias = 1'b0;
		cfg_unit = '0;
		cfg_addr = '0;
		cfg_data = '0;
		test_errors = 0;
		total_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		cur_test = "reset";
		repeat (3) @(negedge clk);
		rst = 1'b0;

		start_test("reset_idle");
		repeat (10) begin
			@(negedge clk);
			if (out_valid !== 1'b0 || busy !== 1'b0) begin
				note_problem("out_valid or busy high with no pixel sent");
			end
		end
		finish_test();

		for (int u = 0; u < `NUM_UNITS; u++) load_kernel(u, 1'b0);
		start_test("single_channel");
		fill_stream(1);
		run_output(1, 1'b0, 1'b0);
		finish_test();

		start_test("multi_channel");
		for (int n = 0; n < 6; n++) begin
			depth = (n == 0) ? `MAX_DEPTH : ($random(seed) & 7) + 1;
			fill_stream(depth);
			run_output(depth, 1'b0, 1'b0);
		end
		finish_test();

		for (int u = 0; u < `NUM_UNITS; u++) load_kernel(u, 1'b1);
		start_test("relu");
		for (int n = 0; n < 2; n++) begin
			fill_stream(n + 1);
			run_output(n + 1, 1'b1, 1'b0);
		end
		finish_test();

		start_test("pixel_gaps");
		depth = ($random(seed) & 7) + 1;
		fill_stream(depth);
		run_output(depth, 1'b0, 1'b0);
		ref_res = last_res;
		run_output(depth, 1'b0, 1'b1);
		for (int u = 0; u < `NUM_UNITS; u++) begin
			if (last_res[u] !== ref_res[u]) begin
				note_mismatch($sformatf("unit %0d gapped result", u), ref_res[u], last_res[u]);
			end
		end
		finish_test();

		start_test("rewrite_one_unit");
		pick = $random(seed) & 3;
		depth = ($random(seed) & 7) + 1;
		fill_stream(depth);
		run_output(depth, 1'b0, 1'b0);
		ref_res = last_res;
		load_kernel(pick, 1'b0);
		run_output(depth, 1'b0, 1'b0);
		for (int u = 0; u < `NUM_UNITS; u++) begin
			if (u != pick && last_res[u] !== ref_res[u]) begin
				note_mismatch($sformatf("untouched unit %0d", u), ref_res[u], last_res[u]);
			end
		end
		if (last_res[pick] === ref_res[pick]) note_problem("rewritten unit kept its old result");
		finish_test();

		$display("summary: %0d tests, %0d ok, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, total_errors);
		if (total_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: conv_cluster.f
+incdir+logic
+incdir+dv
logic/conv_pkg.sv
logic/window_bus_if.sv
logic/cfg_bus_if.sv
logic/weight_ram.sv
logic/dot_product.sv
logic/window_feeder.sv
logic/filter_unit.sv
logic/result_collector.sv
logic/conv_cluster.sv
dv/tb_conv_cluster.sv
